// ==== source/rv_id_consts.svh ====
`ifndef RV_ID_CONSTS_SVH
`define RV_ID_CONSTS_SVH

// Datapath widths
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_INSTR_W     32

// RV32I base opcodes
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011
`define RV_OP_SYSTEM   7'b1110011

// Trap causes
`define RV_TRAP_NONE     2'd0
`define RV_TRAP_ILLEGAL  2'd1
`define RV_TRAP_EBREAK   2'd2

// Write-back result source
`define RV_RES_ALU  2'd0
`define RV_RES_MEM  2'd1
`define RV_RES_PC4  2'd2

// ALU operand A source
`define RV_ASRC_REG   2'd0
`define RV_ASRC_PC    2'd1
`define RV_ASRC_ZERO  2'd2

`endif

// ==== source/rv_id_pkg.sv ====
`include "rv_id_consts.svh"

package rv_id_pkg;

  // ========================================
  // Datapath types
  // ========================================

  // One architectural data word
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // Register number x0..x31
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // Raw instruction word from fetch
  typedef logic [`RV_INSTR_W-1:0] instr_t;

  // Minor opcode field, bits 14:12
  typedef logic [2:0] funct3_t;

  // ========================================
  // Control field types
  // ========================================

  // Trap cause, see RV_TRAP_* codes
  typedef logic [1:0] trap_code_t;

  // Write-back source, see RV_RES_* codes
  typedef logic [1:0] res_src_t;

  // ALU A operand select, see RV_ASRC_* codes
  typedef logic [1:0] alu_a_src_t;

endpackage

// ==== source/rv_id_ctrl_if.sv ====
`timescale 1ns/10ps

interface rv_id_ctrl_if;

  // Flags that a bubble or flush must clear
  logic reg_write;
  logic mem_read;
  logic mem_write;
  logic is_branch;
  logic is_jal;
  logic is_jalr;

  // Operand and result selects
  logic                   alu_b_src;
  rv_id_pkg::alu_a_src_t  alu_a_src;
  rv_id_pkg::res_src_t    res_src;

  // Decoded fields
  rv_id_pkg::reg_addr_t   rd;
  rv_id_pkg::funct3_t     funct3;
  rv_id_pkg::xlen_t       imm;
  rv_id_pkg::trap_code_t  trap_code;

  modport decoder_mp (
    output reg_write, mem_read, mem_write, is_branch, is_jal, is_jalr,
    output alu_b_src, alu_a_src, res_src, rd, funct3, imm, trap_code
  );

  modport stage_mp (
    input reg_write, mem_read, mem_write, is_branch, is_jal, is_jalr,
    input alu_b_src, alu_a_src, res_src, rd, funct3, imm, trap_code
  );

endinterface

// ==== source/rv_instr_decoder.sv ====
`timescale 1ns/10ps
`include "rv_id_consts.svh"

module rv_instr_decoder (
  input  rv_id_pkg::instr_t    instr_i,
  rv_id_ctrl_if.decoder_mp     ctrl,
  output rv_id_pkg::reg_addr_t rs1_o,
  output rv_id_pkg::reg_addr_t rs2_o,
  output logic                 rs1_used_o,
  output logic                 rs2_used_o
);

  logic [6:0]         opcode;
  rv_id_pkg::funct3_t funct3;
  rv_id_pkg::xlen_t   imm_i;
  rv_id_pkg::xlen_t   imm_s;
  rv_id_pkg::xlen_t   imm_b;
  rv_id_pkg::xlen_t   imm_u;
  rv_id_pkg::xlen_t   imm_j;
  logic               illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  // Register fields sit at fixed positions in every format
  assign rs1_o       = instr_i[19:15];
  assign rs2_o       = instr_i[24:20];
  assign ctrl.rd     = instr_i[11:7];
  assign ctrl.funct3 = funct3;

  // ========================================
  // Immediate formats
  // ========================================

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // ========================================
  // Opcode decode
  // ========================================

  always_comb begin
    ctrl.reg_write = 1'b0;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.alu_b_src = 1'b1;
    ctrl.alu_a_src = `RV_ASRC_REG;
    ctrl.res_src   = `RV_RES_ALU;
    ctrl.imm       = imm_i;
    ctrl.trap_code = `RV_TRAP_NONE;
    rs1_used_o     = 1'b0;
    rs2_used_o     = 1'b0;
    illegal        = 1'b0;

    case (opcode)
      `RV_OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = `RV_ASRC_ZERO;
        ctrl.imm       = imm_u;
      end
      `RV_OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = `RV_ASRC_PC;
        ctrl.imm       = imm_u;
      end
      `RV_OP_JAL: begin
        // ALU forms the target from PC, rd gets pc+4
        ctrl.reg_write = 1'b1;
        ctrl.is_jal    = 1'b1;
        ctrl.alu_a_src = `RV_ASRC_PC;
        ctrl.res_src   = `RV_RES_PC4;
        ctrl.imm       = imm_j;
      end
      `RV_OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jalr   = 1'b1;
        ctrl.res_src   = `RV_RES_PC4;
        rs1_used_o     = 1'b1;
        illegal        = (funct3 != 3'd0);
      end
      `RV_OP_BRANCH: begin
        ctrl.is_branch = 1'b1;
        ctrl.alu_b_src = 1'b0;
        ctrl.imm       = imm_b;
        rs1_used_o     = 1'b1;
        rs2_used_o     = 1'b1;
        illegal        = (funct3 == 3'd2) || (funct3 == 3'd3);
      end
      `RV_OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.res_src   = `RV_RES_MEM;
        rs1_used_o     = 1'b1;
        // LB LH LW LBU LHU only
        illegal        = (funct3 == 3'd3) || (funct3 == 3'd6) || (funct3 == 3'd7);
      end
      `RV_OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.imm       = imm_s;
        rs1_used_o     = 1'b1;
        rs2_used_o     = 1'b1;
        illegal        = (funct3 > 3'd2);
      end
      `RV_OP_IMM: begin
        ctrl.reg_write = 1'b1;
        rs1_used_o     = 1'b1;
      end
      `RV_OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_src = 1'b0;
        ctrl.imm       = '0;
        rs1_used_o     = 1'b1;
        rs2_used_o     = 1'b1;
      end
      `RV_OP_SYSTEM: begin
        // EBREAK is the only SYSTEM encoding supported here
        if (instr_i[31:20] == 12'h001 && instr_i[19:7] == '0) begin
          ctrl.trap_code = `RV_TRAP_EBREAK;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase

    // Illegal encodings must not touch state downstream
    if (illegal) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.is_branch = 1'b0;
      ctrl.is_jal    = 1'b0;
      ctrl.is_jalr   = 1'b0;
      ctrl.trap_code = `RV_TRAP_ILLEGAL;
    end
  end

endmodule

// ==== source/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile #(
  parameter int WRITE_THROUGH = 1
) (
  input  logic                 clk,
  input  rv_id_pkg::reg_addr_t rs1_addr_i,
  input  rv_id_pkg::reg_addr_t rs2_addr_i,
  output rv_id_pkg::xlen_t     rs1_data_o,
  output rv_id_pkg::xlen_t     rs2_data_o,
  input  logic                 wr_en_i,
  input  rv_id_pkg::reg_addr_t wr_addr_i,
  input  rv_id_pkg::xlen_t     wr_data_i
);

  // x1..x31 only, x0 has no storage
  rv_id_pkg::xlen_t regs [31:1];

  always_ff @(posedge clk) begin
    if (wr_en_i && wr_addr_i != '0) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // Shared read port logic
  function automatic rv_id_pkg::xlen_t read_port(input rv_id_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (WRITE_THROUGH != 0 && wr_en_i && wr_addr_i == addr) begin
      // Same-cycle write-back is visible to the reader
      return wr_data_i;
    end else begin
      return regs[addr];
    end
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
  end

  always_comb begin
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

// ==== source/rv_id_ex_reg.sv ====
`timescale 1ns/10ps
`include "rv_id_consts.svh"

module rv_id_ex_reg (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  s_valid_i,
  input  logic                  stall_i,
  input  logic                  data_hazard_i,
  input  logic                  flush_i,
  output logic                  m_valid_o,
  input  logic                  m_ready_i,
  rv_id_ctrl_if.stage_mp        ctrl,
  input  rv_id_pkg::reg_addr_t  rs1_addr_i,
  input  rv_id_pkg::reg_addr_t  rs2_addr_i,
  input  rv_id_pkg::xlen_t      rs1_data_i,
  input  rv_id_pkg::xlen_t      rs2_data_i,
  input  rv_id_pkg::xlen_t      pc_i,
  output logic                  reg_write_o,
  output logic                  mem_read_o,
  output logic                  mem_write_o,
  output logic                  is_branch_o,
  output logic                  is_jal_o,
  output logic                  is_jalr_o,
  output logic                  alu_b_src_o,
  output rv_id_pkg::alu_a_src_t alu_a_src_o,
  output rv_id_pkg::res_src_t   res_src_o,
  output rv_id_pkg::trap_code_t trap_code_o,
  output rv_id_pkg::reg_addr_t  rd_o,
  output rv_id_pkg::reg_addr_t  rs1_o,
  output rv_id_pkg::reg_addr_t  rs2_o,
  output rv_id_pkg::funct3_t    funct3_o,
  output rv_id_pkg::xlen_t      imm_o,
  output rv_id_pkg::xlen_t      rs1_data_o,
  output rv_id_pkg::xlen_t      rs2_data_o,
  output rv_id_pkg::xlen_t      pc_o
);

  logic advance;
  logic kill;

  // Move when not stalled and the slot is empty or being taken
  assign advance = !stall_i && (!m_valid_o || m_ready_i);
  assign kill    = data_hazard_i || flush_i;

  // ========================================
  // Control state
  // ========================================

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      m_valid_o   <= 1'b0;
      reg_write_o <= 1'b0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
      is_branch_o <= 1'b0;
      is_jal_o    <= 1'b0;
      is_jalr_o   <= 1'b0;
      trap_code_o <= `RV_TRAP_NONE;
    end else if (advance && !kill) begin
      m_valid_o   <= s_valid_i;
      reg_write_o <= ctrl.reg_write;
      mem_read_o  <= ctrl.mem_read;
      mem_write_o <= ctrl.mem_write;
      is_branch_o <= ctrl.is_branch;
      is_jal_o    <= ctrl.is_jal;
      is_jalr_o   <= ctrl.is_jalr;
      trap_code_o <= ctrl.trap_code;
    end else if (advance || flush_i) begin
      // Bubble on capture, or flush of the held entry
      m_valid_o   <= 1'b0;
      reg_write_o <= 1'b0;
      mem_read_o  <= 1'b0;
      mem_write_o <= 1'b0;
      is_branch_o <= 1'b0;
      is_jal_o    <= 1'b0;
      is_jalr_o   <= 1'b0;
      trap_code_o <= `RV_TRAP_NONE;
    end
  end

  // ========================================
  // Payload
  // ========================================

  always_ff @(posedge clk) begin
    if (advance) begin
      alu_b_src_o <= ctrl.alu_b_src;
      alu_a_src_o <= ctrl.alu_a_src;
      res_src_o   <= ctrl.res_src;
      rd_o        <= ctrl.rd;
      funct3_o    <= ctrl.funct3;
      imm_o       <= ctrl.imm;
      rs1_o       <= rs1_addr_i;
      rs2_o       <= rs2_addr_i;
      rs1_data_o  <= rs1_data_i;
      rs2_data_o  <= rs2_data_i;
      pc_o        <= pc_i;
    end
  end

endmodule

// ==== source/rv_stage_id.sv ====
`timescale 1ns/10ps

module rv_stage_id (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  s_valid_i,
  input  rv_id_pkg::instr_t     instr_i,
  input  rv_id_pkg::xlen_t      pc_i,
  input  logic                  stall_i,
  input  logic                  data_hazard_i,
  input  logic                  flush_i,
  // Write-back port
  input  logic                  reg_write_wb_i,
  input  rv_id_pkg::reg_addr_t  rd_wb_i,
  input  rv_id_pkg::xlen_t      rd_data_wb_i,
  // To EX
  output logic                  m_valid_o,
  input  logic                  m_ready_i,
  output logic                  reg_write_ex_o,
  output logic                  mem_read_ex_o,
  output logic                  mem_write_ex_o,
  output logic                  is_branch_ex_o,
  output logic                  is_jal_ex_o,
  output logic                  is_jalr_ex_o,
  output logic                  alu_b_src_ex_o,
  output rv_id_pkg::alu_a_src_t alu_a_src_ex_o,
  output rv_id_pkg::res_src_t   res_src_ex_o,
  output rv_id_pkg::trap_code_t trap_code_ex_o,
  output rv_id_pkg::reg_addr_t  rd_ex_o,
  output rv_id_pkg::reg_addr_t  rs1_ex_o,
  output rv_id_pkg::reg_addr_t  rs2_ex_o,
  output rv_id_pkg::funct3_t    funct3_ex_o,
  output rv_id_pkg::xlen_t      imm_ex_o,
  output rv_id_pkg::xlen_t      rs1_data_ex_o,
  output rv_id_pkg::xlen_t      rs2_data_ex_o,
  output rv_id_pkg::xlen_t      pc_ex_o,
  // To hazard unit
  output rv_id_pkg::reg_addr_t  rs1_id_o,
  output rv_id_pkg::reg_addr_t  rs2_id_o,
  output logic                  rs1_used_id_o,
  output logic                  rs2_used_id_o
);

  rv_id_pkg::xlen_t rs1_data_id;
  rv_id_pkg::xlen_t rs2_data_id;

  rv_id_ctrl_if ctrl_if ();

  rv_instr_decoder u_decoder (
    .instr_i    (instr_i),
    .ctrl       (ctrl_if.decoder_mp),
    .rs1_o      (rs1_id_o),
    .rs2_o      (rs2_id_o),
    .rs1_used_o (rs1_used_id_o),
    .rs2_used_o (rs2_used_id_o)
  );

  rv_regfile #(
    .WRITE_THROUGH (1)
  ) u_regfile (
    .clk        (clk),
    .rs1_addr_i (rs1_id_o),
    .rs2_addr_i (rs2_id_o),
    .rs1_data_o (rs1_data_id),
    .rs2_data_o (rs2_data_id),
    .wr_en_i    (reg_write_wb_i),
    .wr_addr_i  (rd_wb_i),
    .wr_data_i  (rd_data_wb_i)
  );

  rv_id_ex_reg u_id_ex (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .s_valid_i     (s_valid_i),
    .stall_i       (stall_i),
    .data_hazard_i (data_hazard_i),
    .flush_i       (flush_i),
    .m_valid_o     (m_valid_o),
    .m_ready_i     (m_ready_i),
    .ctrl          (ctrl_if.stage_mp),
    .rs1_addr_i    (rs1_id_o),
    .rs2_addr_i    (rs2_id_o),
    .rs1_data_i    (rs1_data_id),
    .rs2_data_i    (rs2_data_id),
    .pc_i          (pc_i),
    .reg_write_o   (reg_write_ex_o),
    .mem_read_o    (mem_read_ex_o),
    .mem_write_o   (mem_write_ex_o),
    .is_branch_o   (is_branch_ex_o),
    .is_jal_o      (is_jal_ex_o),
    .is_jalr_o     (is_jalr_ex_o),
    .alu_b_src_o   (alu_b_src_ex_o),
    .alu_a_src_o   (alu_a_src_ex_o),
    .res_src_o     (res_src_ex_o),
    .trap_code_o   (trap_code_ex_o),
    .rd_o          (rd_ex_o),
    .rs1_o         (rs1_ex_o),
    .rs2_o         (rs2_ex_o),
    .funct3_o      (funct3_ex_o),
    .imm_o         (imm_ex_o),
    .rs1_data_o    (rs1_data_ex_o),
    .rs2_data_o    (rs2_data_ex_o),
    .pc_o          (pc_ex_o)
  );

endmodule

// ==== bench/rv_stage_id_assert.sv ====
`timescale 1ns/10ps
`include "rv_id_consts.svh"

module rv_stage_id_assert (
  input logic                  clk,
  input logic                  rst_n_i,
  input logic                  m_valid_o,
  input logic                  m_ready_i,
  input logic                  flush_i,
  input logic                  reg_write_ex_o,
  input rv_id_pkg::trap_code_t trap_code_ex_o,
  input rv_id_pkg::xlen_t      pc_ex_o,
  input rv_id_pkg::xlen_t      imm_ex_o,
  input rv_id_pkg::reg_addr_t  rd_ex_o
);

  // Nothing leaves the stage while reset is applied
  reset_clears_valid: assert property (@(posedge clk) !rst_n_i |-> !m_valid_o)
    else $error("m_valid_o high during reset");

  // A waiting entry keeps its payload until EX takes it
  held_entry_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    (m_valid_o && !m_ready_i && !flush_i) |=>
      (m_valid_o && $stable(pc_ex_o) && $stable(imm_ex_o) && $stable(rd_ex_o)))
    else $error("held ID/EX entry changed before m_ready_i");

  trap_blocks_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    (trap_code_ex_o != `RV_TRAP_NONE) |-> !reg_write_ex_o)
    else $error("reg_write_ex_o set on a trapping instruction");

endmodule

bind rv_stage_id rv_stage_id_assert u_assert (
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .m_valid_o      (m_valid_o),
  .m_ready_i      (m_ready_i),
  .flush_i        (flush_i),
  .reg_write_ex_o (reg_write_ex_o),
  .trap_code_ex_o (trap_code_ex_o),
  .pc_ex_o        (pc_ex_o),
  .imm_ex_o       (imm_ex_o),
  .rd_ex_o        (rd_ex_o)
);

// ==== bench/tb_rv_stage_id.sv ====
`timescale 1ns/10ps
`include "rv_id_consts.svh"

module tb_rv_stage_id;

  localparam int TIMEOUT_CYCLES = 3000;

  // Fixed register numbers used by the directed encodings
  localparam rv_id_pkg::reg_addr_t SRC1 = 5'd3;
  localparam rv_id_pkg::reg_addr_t SRC2 = 5'd4;
  localparam rv_id_pkg::reg_addr_t DEST = 5'd7;

  logic clk, rst_n_i, s_valid_i, stall_i, data_hazard_i, flush_i, m_ready_i;
  rv_id_pkg::instr_t     instr_i;
  rv_id_pkg::xlen_t      pc_i;
  logic                  reg_write_wb_i;
  rv_id_pkg::reg_addr_t  rd_wb_i;
  rv_id_pkg::xlen_t      rd_data_wb_i;

  logic m_valid_o, reg_write_ex_o, mem_read_ex_o, mem_write_ex_o;
  logic is_branch_ex_o, is_jal_ex_o, is_jalr_ex_o, alu_b_src_ex_o;
  rv_id_pkg::alu_a_src_t alu_a_src_ex_o;
  rv_id_pkg::res_src_t   res_src_ex_o;
  rv_id_pkg::trap_code_t trap_code_ex_o;
  rv_id_pkg::reg_addr_t  rd_ex_o, rs1_ex_o, rs2_ex_o, rs1_id_o, rs2_id_o;
  rv_id_pkg::funct3_t    funct3_ex_o;
  rv_id_pkg::xlen_t      imm_ex_o, rs1_data_ex_o, rs2_data_ex_o, pc_ex_o;
  logic                  rs1_used_id_o, rs2_used_id_o;

  int          cycle_count = 0;
  logic [31:0] rng_state = 32'd84109;

  rv_stage_id dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_with_failure($sformatf("timeout after %0d cycles, tests did not finish", cycle_count));
  end

  // ========================================
  // Reporting and compare tasks
  // ========================================

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    stop_with_failure($sformatf("error: %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
  endtask

  task automatic check_xlen(input string name, input rv_id_pkg::xlen_t exp_v,
                            input rv_id_pkg::xlen_t act_v);
    if (act_v !== exp_v) report_mismatch(name, exp_v, act_v);
  endtask

  task automatic check_reg_addr(input string name, input rv_id_pkg::reg_addr_t exp_v,
                                input rv_id_pkg::reg_addr_t act_v);
    if (act_v !== exp_v) report_mismatch(name, 32'(exp_v), 32'(act_v));
  endtask

  task automatic check_trap(input string name, input rv_id_pkg::trap_code_t exp_v,
                            input rv_id_pkg::trap_code_t act_v);
    if (act_v !== exp_v) report_mismatch(name, 32'(exp_v), 32'(act_v));
  endtask

  task automatic check_res_src(input string name, input rv_id_pkg::res_src_t exp_v,
                               input rv_id_pkg::res_src_t act_v);
    if (act_v !== exp_v) report_mismatch(name, 32'(exp_v), 32'(act_v));
  endtask

  task automatic check_alu_a(input string name, input rv_id_pkg::alu_a_src_t exp_v,
                             input rv_id_pkg::alu_a_src_t act_v);
    if (act_v !== exp_v) report_mismatch(name, 32'(exp_v), 32'(act_v));
  endtask

  task automatic check_funct3(input string name, input rv_id_pkg::funct3_t exp_v,
                              input rv_id_pkg::funct3_t act_v);
    if (act_v !== exp_v) report_mismatch(name, 32'(exp_v), 32'(act_v));
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) report_mismatch(name, 32'(exp_v), 32'(act_v));
  endtask

  // ========================================
  // Encoders, stimulus and random numbers
  // ========================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic rv_id_pkg::instr_t enc_i(input logic [11:0] imm,
      input rv_id_pkg::reg_addr_t rs1, input rv_id_pkg::funct3_t f3, input logic [6:0] opc);
    return {imm, rs1, f3, DEST, opc};
  endfunction

  function automatic rv_id_pkg::instr_t enc_r(input rv_id_pkg::reg_addr_t rs1,
      input rv_id_pkg::reg_addr_t rs2, input rv_id_pkg::funct3_t f3);
    return {7'b0, rs2, rs1, f3, DEST, `RV_OP_REG};
  endfunction

  function automatic rv_id_pkg::instr_t enc_s(input logic [11:0] imm, input rv_id_pkg::funct3_t f3);
    return {imm[11:5], SRC2, SRC1, f3, imm[4:0], `RV_OP_STORE};
  endfunction

  function automatic rv_id_pkg::instr_t enc_b(input logic [12:0] imm, input rv_id_pkg::funct3_t f3);
    return {imm[12], imm[10:5], SRC2, SRC1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic rv_id_pkg::instr_t enc_u(input logic [19:0] imm, input logic [6:0] opc);
    return {imm, DEST, opc};
  endfunction

  function automatic rv_id_pkg::instr_t enc_j(input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], DEST, `RV_OP_JAL};
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  // Present an instruction and let the decode settle
  task automatic issue(input rv_id_pkg::instr_t instr, input rv_id_pkg::xlen_t pc);
    s_valid_i = 1'b1;
    instr_i   = instr;
    pc_i      = pc;
    #1;
  endtask

  task automatic send(input rv_id_pkg::instr_t instr, input rv_id_pkg::xlen_t pc);
    issue(instr, pc);
    tick();
    s_valid_i = 1'b0;
  endtask

  task automatic write_reg(input rv_id_pkg::reg_addr_t addr, input rv_id_pkg::xlen_t data);
    reg_write_wb_i = 1'b1;
    rd_wb_i        = addr;
    rd_data_wb_i   = data;
    tick();
    reg_write_wb_i = 1'b0;
  endtask

  // ========================================
  // Directed tests
  // ========================================

  // flags order is reg_write mem_read mem_write branch jal jalr
  task automatic run_class(input string name, input rv_id_pkg::instr_t instr,
      input rv_id_pkg::funct3_t f3, input logic [1:0] used, input logic [5:0] flags,
      input logic b_src, input rv_id_pkg::alu_a_src_t a_src, input rv_id_pkg::res_src_t res,
      input rv_id_pkg::xlen_t imm, input rv_id_pkg::trap_code_t trap);
    issue(instr, 32'h0000_1000);
    check_bit({name, " rs1 used"}, used[1], rs1_used_id_o);
    check_bit({name, " rs2 used"}, used[0], rs2_used_id_o);
    if (used[1]) check_reg_addr({name, " rs1 id"}, SRC1, rs1_id_o);
    if (used[0]) check_reg_addr({name, " rs2 id"}, SRC2, rs2_id_o);
    tick();
    s_valid_i = 1'b0;
    check_bit({name, " valid"}, 1'b1, m_valid_o);
    check_bit({name, " reg_write"}, flags[5], reg_write_ex_o);
    check_bit({name, " mem_read"}, flags[4], mem_read_ex_o);
    check_bit({name, " mem_write"}, flags[3], mem_write_ex_o);
    check_bit({name, " branch"}, flags[2], is_branch_ex_o);
    check_bit({name, " jal"}, flags[1], is_jal_ex_o);
    check_bit({name, " jalr"}, flags[0], is_jalr_ex_o);
    check_bit({name, " alu_b_src"}, b_src, alu_b_src_ex_o);
    check_alu_a({name, " alu_a_src"}, a_src, alu_a_src_ex_o);
    check_res_src({name, " res_src"}, res, res_src_ex_o);
    check_trap({name, " trap"}, trap, trap_code_ex_o);
    check_xlen({name, " imm"}, imm, imm_ex_o);
    check_xlen({name, " pc"}, 32'h0000_1000, pc_ex_o);
    if (used[1]) check_reg_addr({name, " rs1 ex"}, SRC1, rs1_ex_o);
    if (used[0]) check_reg_addr({name, " rs2 ex"}, SRC2, rs2_ex_o);
    if (flags[5]) check_reg_addr({name, " rd"}, DEST, rd_ex_o);
    if (used[1]) check_funct3({name, " funct3"}, f3, funct3_ex_o);
  endtask

  task automatic test_decode_classes();
    run_class("lui", enc_u(20'hABCDE, `RV_OP_LUI), 3'd0, 2'b00, 6'b100000, 1'b1,
              `RV_ASRC_ZERO, `RV_RES_ALU, 32'hABCD_E000, `RV_TRAP_NONE);
    run_class("auipc", enc_u(20'h80001, `RV_OP_AUIPC), 3'd0, 2'b00, 6'b100000, 1'b1,
              `RV_ASRC_PC, `RV_RES_ALU, 32'h8000_1000, `RV_TRAP_NONE);
    run_class("jal", enc_j(21'h1F2346), 3'd0, 2'b00, 6'b100010, 1'b1,
              `RV_ASRC_PC, `RV_RES_PC4, 32'hFFFF_2346, `RV_TRAP_NONE);
    run_class("jalr", enc_i(12'h010, SRC1, 3'd0, `RV_OP_JALR), 3'd0, 2'b10, 6'b100001, 1'b1,
              `RV_ASRC_REG, `RV_RES_PC4, 32'h0000_0010, `RV_TRAP_NONE);
    run_class("bne", enc_b(13'h1FF4, 3'd1), 3'd1, 2'b11, 6'b000100, 1'b0,
              `RV_ASRC_REG, `RV_RES_ALU, 32'hFFFF_FFF4, `RV_TRAP_NONE);
    run_class("lw", enc_i(12'hFFC, SRC1, 3'd2, `RV_OP_LOAD), 3'd2, 2'b10, 6'b110000, 1'b1,
              `RV_ASRC_REG, `RV_RES_MEM, 32'hFFFF_FFFC, `RV_TRAP_NONE);
    run_class("sw", enc_s(12'h123, 3'd2), 3'd2, 2'b11, 6'b001000, 1'b1,
              `RV_ASRC_REG, `RV_RES_ALU, 32'h0000_0123, `RV_TRAP_NONE);
    run_class("addi", enc_i(12'h87F, SRC1, 3'd0, `RV_OP_IMM), 3'd0, 2'b10, 6'b100000, 1'b1,
              `RV_ASRC_REG, `RV_RES_ALU, 32'hFFFF_F87F, `RV_TRAP_NONE);
    run_class("add", enc_r(SRC1, SRC2, 3'd0), 3'd0, 2'b11, 6'b100000, 1'b0,
              `RV_ASRC_REG, `RV_RES_ALU, 32'h0, `RV_TRAP_NONE);
    run_class("ebreak", 32'h0010_0073, 3'd0, 2'b00, 6'b000000, 1'b1,
              `RV_ASRC_REG, `RV_RES_ALU, 32'h0000_0001, `RV_TRAP_EBREAK);
  endtask

  task automatic test_regfile();
    write_reg(SRC1, 32'h1234_5678);
    write_reg(SRC2, 32'hCAFE_0001);
    send(enc_r(SRC1, SRC2, 3'd0), 32'h2000);
    check_xlen("regfile rs1", 32'h1234_5678, rs1_data_ex_o);
    check_xlen("regfile rs2", 32'hCAFE_0001, rs2_data_ex_o);
    write_reg(5'd0, 32'hDEAD_BEEF);
    // x0 stays zero even with a write to it in the same cycle
    reg_write_wb_i = 1'b1;
    rd_wb_i        = 5'd0;
    rd_data_wb_i   = 32'hDEAD_BEEF;
    send(enc_r(5'd0, SRC2, 3'd0), 32'h2004);
    reg_write_wb_i = 1'b0;
    check_xlen("regfile x0", 32'h0, rs1_data_ex_o);
    // Write-back to x9 lands at the same edge that captures the read
    reg_write_wb_i = 1'b1;
    rd_wb_i        = 5'd9;
    rd_data_wb_i   = 32'h0BAD_F00D;
    send(enc_r(5'd9, SRC1, 3'd0), 32'h2008);
    reg_write_wb_i = 1'b0;
    check_xlen("write-through rs1", 32'h0BAD_F00D, rs1_data_ex_o);
    check_xlen("write-through rs2", 32'h1234_5678, rs2_data_ex_o);
  endtask

  task automatic expect_trap(input string name, input rv_id_pkg::instr_t instr,
                             input rv_id_pkg::trap_code_t trap);
    send(instr, 32'h3000);
    check_bit({name, " valid"}, 1'b1, m_valid_o);
    check_trap({name, " trap"}, trap, trap_code_ex_o);
    check_bit({name, " reg_write"}, 1'b0, reg_write_ex_o);
    check_bit({name, " mem_read"}, 1'b0, mem_read_ex_o);
  endtask

  task automatic test_traps();
    expect_trap("unknown opcode", enc_i(12'h0, SRC1, 3'd0, 7'b1111111), `RV_TRAP_ILLEGAL);
    expect_trap("load funct3", enc_i(12'h4, SRC1, 3'd3, `RV_OP_LOAD), `RV_TRAP_ILLEGAL);
    expect_trap("jalr funct3", enc_i(12'h4, SRC1, 3'd1, `RV_OP_JALR), `RV_TRAP_ILLEGAL);
    expect_trap("ecall", 32'h0000_0073, `RV_TRAP_ILLEGAL);
    expect_trap("ebreak", 32'h0010_0073, `RV_TRAP_EBREAK);
  endtask

  task automatic test_backpressure_stall();
    send(enc_i(12'h055, SRC1, 3'd0, `RV_OP_IMM), 32'h4000);
    m_ready_i = 1'b0;
    issue(enc_i(12'h066, SRC1, 3'd0, `RV_OP_IMM), 32'h4004);
    repeat (3) begin
      check_bit("backpressure valid", 1'b1, m_valid_o);
      check_xlen("backpressure pc", 32'h4000, pc_ex_o);
      check_xlen("backpressure imm", 32'h55, imm_ex_o);
      tick();
    end
    m_ready_i = 1'b1;
    tick();
    check_xlen("released pc", 32'h4004, pc_ex_o);
    check_xlen("released imm", 32'h66, imm_ex_o);
    stall_i = 1'b1;
    issue(enc_i(12'h077, SRC1, 3'd0, `RV_OP_IMM), 32'h4008);
    repeat (3) begin
      check_xlen("stall pc", 32'h4004, pc_ex_o);
      check_xlen("stall imm", 32'h66, imm_ex_o);
      tick();
    end
    stall_i = 1'b0;
    tick();
    s_valid_i = 1'b0;
    check_bit("unstall valid", 1'b1, m_valid_o);
    check_xlen("unstall pc", 32'h4008, pc_ex_o);
  endtask

  task automatic test_bubble_flush();
    data_hazard_i = 1'b1;
    send(enc_i(12'h011, SRC1, 3'd0, `RV_OP_IMM), 32'h5000);
    data_hazard_i = 1'b0;
    check_bit("bubble valid", 1'b0, m_valid_o);
    check_bit("bubble reg_write", 1'b0, reg_write_ex_o);
    m_ready_i = 1'b0;
    send(enc_i(12'h022, SRC1, 3'd2, `RV_OP_LOAD), 32'h5004);
    check_bit("pre-flush mem_read", 1'b1, mem_read_ex_o);
    pc_i    = 32'h5008;
    flush_i = 1'b1;
    tick();
    flush_i = 1'b0;
    check_bit("flush valid", 1'b0, m_valid_o);
    check_bit("flush reg_write", 1'b0, reg_write_ex_o);
    check_bit("flush mem_read", 1'b0, mem_read_ex_o);
    check_xlen("flush pc held", 32'h5004, pc_ex_o);
    m_ready_i = 1'b1;
  endtask

  task automatic test_random_operands();
    logic [31:0]          value;
    logic [31:0]          draw;
    rv_id_pkg::reg_addr_t src;
    logic [11:0]          imm12;
    for (int i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      value     = rng_state;
      rng_state = xorshift32(rng_state);
      draw      = rng_state;
      src       = rv_id_pkg::reg_addr_t'(draw % 31 + 1);
      imm12     = draw[31:20];
      write_reg(src, value);
      send(enc_i(imm12, src, 3'd0, `RV_OP_IMM), 32'h6000);
      check_xlen("random imm", 32'($signed(imm12)), imm_ex_o);
      check_xlen("random rs1 data", value, rs1_data_ex_o);
    end
  endtask

  initial begin
    rst_n_i        = 1'b0;
    s_valid_i      = 1'b0;
    instr_i        = '0;
    pc_i           = '0;
    stall_i        = 1'b0;
    data_hazard_i  = 1'b0;
    flush_i        = 1'b0;
    reg_write_wb_i = 1'b0;
    rd_wb_i        = '0;
    rd_data_wb_i   = '0;
    m_ready_i      = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    check_bit("reset valid", 1'b0, m_valid_o);
    check_trap("reset trap", `RV_TRAP_NONE, trap_code_ex_o);
    test_decode_classes();
    test_regfile();
    test_traps();
    test_backpressure_stall();
    test_bubble_flush();
    test_random_operands();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+source
source/rv_id_pkg.sv
source/rv_id_ctrl_if.sv
source/rv_instr_decoder.sv
source/rv_regfile.sv
source/rv_id_ex_reg.sv
source/rv_stage_id.sv
bench/rv_stage_id_assert.sv
bench/tb_rv_stage_id.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_rv_stage_id -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rv_stage_id
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
